// File: flist.f
rtl/sdram_mcb_pkg.sv
rtl/mcb_stage_if.sv
rtl/mcb_fifo.sv
rtl/mcb_job_channel.sv
rtl/mcb_scheduler.sv
rtl/sdram_mcb.sv
dv/sdram_mcb_assert.sv
dv/tb_sdram_mcb.sv

// File: dv/tb_sdram_mcb.sv
`timescale 1ns/1ps
module tb_sdram_mcb;

  localparam int max_wait = 20000;  // cycles allowed per wait loop

  logic                               clk_sdram;
  logic                               rst_n;
  logic                               core_init_done;
  logic                               wr_load, wr_load_ready, wr_req, wr_done, wr_rdy;
  logic                               wr_overrun;
  logic                               rd_load, rd_load_ready, rd_req, rd_done;
  logic                               rd_fifo_empty, rd_underrun;
  logic                               burst_wr_req, burst_rd_req, burst_wr_ack, burst_rd_ack;
  logic [sdram_mcb_pkg::addr_w-1:0]   wr_addr, rd_addr, burst_addr;
  logic [sdram_mcb_pkg::len_w-1:0]    wr_length, rd_length;
  logic [sdram_mcb_pkg::data_w-1:0]   din, dout, burst_wdata, burst_rdata;
  logic [sdram_mcb_pkg::cnt_w-1:0]    rd_fifo_cnt;
  logic [sdram_mcb_pkg::stage_w-1:0]  burst_len;

  logic [15:0] lfsr = 16'd44852;
  logic [15:0] mem_model [logic [23:0]];  // sparse sdram contents
  logic [15:0] wr_q [$];                  // words pushed for the current write job
  logic [15:0] rd_q [$];                  // words the read job must return
  bit          burst_log [$];             // 1 marks a read burst
  logic [23:0] exp_addr [2];              // next stage start, index 1 is read
  int          exp_left [2];              // words not yet covered by bursts
  int          wr_done_cnt = 0;
  int          rd_done_cnt = 0;
  int          overrun_cnt = 0;
  int          underrun_cnt = 0;
  int          rd_fill = 0;               // read fifo words per the model
  int          errors = 0;
  int          tests = 0;
  int          test_base = 0;

  sdram_mcb u_sdram_mcb (.*);

  always #50 clk_sdram = ~clk_sdram;

  // pulse counters
  always @(posedge clk_sdram) begin
    wr_done_cnt  <= wr_done_cnt + (wr_done === 1'b1);
    rd_done_cnt  <= rd_done_cnt + (rd_done === 1'b1);
    overrun_cnt  <= overrun_cnt + (wr_overrun === 1'b1);
    underrun_cnt <= underrun_cnt + (rd_underrun === 1'b1);
  end

  // read fifo level, up on each read ack given, down on each pop of a non-empty fifo
  always @(posedge clk_sdram) begin
    if (rst_n) begin
      assert (rd_fifo_cnt === sdram_mcb_pkg::cnt_w'(rd_fill) &&
              rd_fifo_empty === (rd_fill == 0))
        else log_error($sformatf("rd_fifo_cnt %0d empty %b, expected %0d",
                                 rd_fifo_cnt, rd_fifo_empty, rd_fill));
      rd_fill <= rd_fill + (burst_rd_ack === 1'b1) - (rd_req === 1'b1 && rd_fill != 0);
    end
  end

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int k;
    r = '0;
    for (k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
    end
    return r;
  endfunction

  function automatic bit outputs_quiet();
    return !(burst_wr_req || burst_rd_req || wr_done || rd_done || wr_overrun ||
             rd_underrun || wr_load_ready || rd_load_ready || wr_rdy);
  endfunction

  task automatic log_error(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_timeout(input string what);
    $display("timed out at %0t waiting for %s", $time, what);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_base) begin
      $display("test %-30s ok", name);
    end else begin
      $display("test %-30s %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  // command core model, one burst at a time
  task automatic serve_burst(input bit is_rd, input logic [23:0] a, input logic [9:0] len);
    logic [23:0] cur;
    int exp_len;
    int i;
    burst_log.push_back(is_rd);
    exp_len = sdram_mcb_pkg::col_span - int'(a[8:0]);  // room to row end
    if (exp_left[is_rd] < exp_len) exp_len = exp_left[is_rd];
    assert (a == exp_addr[is_rd] && int'(len) == exp_len)
      else log_error($sformatf("burst at %h len %0d, expected %h len %0d",
                               a, len, exp_addr[is_rd], exp_len));
    exp_addr[is_rd] = exp_addr[is_rd] + 24'(len);
    exp_left[is_rd] = exp_left[is_rd] - int'(len);
    repeat (rand_bits(2)) @(posedge clk_sdram);  // core latency
    for (i = 0; i < int'(len); i++) begin
      cur = a + 24'(i);
      if (rand_bits(1)) begin  // gap
        burst_wr_ack <= 1'b0;
        burst_rd_ack <= 1'b0;
        @(posedge clk_sdram);
      end
      if (is_rd) begin
        burst_rd_ack <= 1'b1;
        burst_rdata  <= mem_model.exists(cur) ? mem_model[cur] : 16'h0000;
      end else begin
        burst_wr_ack <= 1'b1;
      end
      @(posedge clk_sdram);
      if (!is_rd) mem_model[cur] = burst_wdata;  // fifo head taken at this edge
    end
    burst_wr_ack <= 1'b0;
    burst_rd_ack <= 1'b0;
  endtask

  always begin
    @(posedge clk_sdram);
    if (burst_wr_req || burst_rd_req) serve_burst(burst_rd_req, burst_addr, burst_len);
  end

  task automatic load_jobs(input bit do_wr, input bit do_rd, input logic [23:0] wa,
                           input int wl, input logic [23:0] ra, input int rl);
    int waits;
    waits = 0;
    if (do_wr) begin
      exp_addr[0] = wa;
      exp_left[0] = wl;
    end
    if (do_rd) begin
      exp_addr[1] = ra;
      exp_left[1] = rl;
    end
    wr_load   <= do_wr;
    rd_load   <= do_rd;
    wr_addr   <= wa;
    wr_length <= sdram_mcb_pkg::len_w'(wl);
    rd_addr   <= ra;
    rd_length <= sdram_mcb_pkg::len_w'(rl);
    do begin
      @(posedge clk_sdram);
      waits++;
    end while (!((wr_load_ready || !do_wr) && (rd_load_ready || !do_rd)) && waits < max_wait);
    if (waits >= max_wait) report_timeout("load ready");
    // keep load high with a wrong address, pending channel must refuse it
    wr_addr <= ~wa;
    rd_addr <= ~ra;
    @(posedge clk_sdram);
    assert (!(do_wr && wr_load_ready) && !(do_rd && rd_load_ready))
      else log_error("second load accepted while a job was pending");
    wr_load <= 1'b0;
    rd_load <= 1'b0;
  endtask

  task automatic push_words(input int n, input bit ignore_rdy);
    logic [15:0] word;
    int i;
    int waits;
    i = 0;
    waits = 0;
    while (i < n && waits < max_wait) begin
      @(posedge clk_sdram);
      wr_req <= 1'b0;
      if (ignore_rdy || (wr_rdy && rand_bits(2) != 0)) begin
        word = 16'(rand_bits(16));
        wr_req <= 1'b1;
        din    <= word;
        wr_q.push_back(word);
        i++;
        waits = 0;
      end else begin
        waits++;
      end
    end
    @(posedge clk_sdram);
    wr_req <= 1'b0;
    if (i < n) report_timeout("wr_rdy");
  endtask

  task automatic pop_words(input int n);
    int got;
    int waits;
    bit popped;
    got = 0;
    waits = 0;
    while (got < n && waits < max_wait) begin
      @(posedge clk_sdram);
      popped = rd_req && !rd_fifo_empty;
      if (popped) begin
        assert (dout == rd_q[got])
          else log_error($sformatf("dout word %0d is %h, expected %h", got, dout, rd_q[got]));
        got++;
        waits = 0;
      end else begin
        waits++;
      end
      // never pop an empty fifo here
      rd_req <= (got < n) && rand_bits(1) && (rd_fifo_cnt > (popped ? 1 : 0));
    end
    rd_req <= 1'b0;
    if (got < n) report_timeout("read data");
  endtask

  task automatic wait_done(input bit rd, input int base);
    int waits;
    waits = 0;
    while ((rd ? rd_done_cnt : wr_done_cnt) == base && waits < max_wait) begin
      @(posedge clk_sdram);
      waits++;
    end
    if (waits >= max_wait) report_timeout(rd ? "rd_done" : "wr_done");
  endtask

  task automatic run_jobs(input bit do_wr, input bit do_rd, input logic [23:0] wa,
                          input int wl, input logic [23:0] ra, input int rl,
                          input bit prefill);
    logic [23:0] cur;
    int wbase;
    int rbase;
    int i;
    wbase = wr_done_cnt;
    rbase = rd_done_cnt;
    if (!prefill) wr_q.delete();
    rd_q.delete();
    for (i = 0; i < rl; i++) rd_q.push_back(mem_model[ra + 24'(i)]);
    load_jobs(do_wr, do_rd, wa, wl, ra, rl);
    fork
      if (do_wr && !prefill) push_words(wl, 1'b0);
      if (do_rd) pop_words(rl);
      if (do_wr) wait_done(1'b0, wbase);
      if (do_rd) wait_done(1'b1, rbase);
    join
    repeat (4) @(posedge clk_sdram);  // room for a stray second pulse
    if (do_wr) begin
      assert (wr_done_cnt == wbase + 1 && exp_left[0] == 0)
        else log_error($sformatf("write job gave %0d wr_done pulses, %0d words not burst",
                                 wr_done_cnt - wbase, exp_left[0]));
      for (i = 0; i < wl; i++) begin
        cur = wa + 24'(i);
        assert (mem_model.exists(cur) && mem_model[cur] == wr_q[i])
          else log_error($sformatf("memory at %h holds %h, expected %h",
                                   cur, mem_model[cur], wr_q[i]));
      end
    end
    if (do_rd) begin
      assert (rd_done_cnt == rbase + 1 && exp_left[1] == 0)
        else log_error($sformatf("read job gave %0d rd_done pulses, %0d words not burst",
                                 rd_done_cnt - rbase, exp_left[1]));
    end
  endtask

  initial begin
    logic [23:0] wa;
    logic [23:0] ra;
    int wl;
    int k;
    int delay;
    clk_sdram      = 1'b0;
    rst_n          = 1'b0;
    core_init_done = 1'b0;
    wr_load        = 1'b0;
    wr_addr        = '0;
    wr_length      = '0;
    wr_req         = 1'b0;
    din            = '0;
    rd_load        = 1'b0;
    rd_addr        = '0;
    rd_length      = '0;
    rd_req         = 1'b0;
    burst_wr_ack   = 1'b0;
    burst_rd_ack   = 1'b0;
    burst_rdata    = '0;

    // 5 reset cycles, then a random wait for the core
    delay = 2 + rand_bits(3);
    for (k = 0; k < 5 + delay; k++) begin
      @(posedge clk_sdram);
      if (k == 4) rst_n <= 1'b1;
      if (k > 0) begin  // first edge is where reset lands
        assert (outputs_quiet()) else log_error("output active before init_done");
      end
    end
    core_init_done <= 1'b1;
    repeat (2) @(posedge clk_sdram);
    assert (wr_rdy && wr_load_ready && rd_load_ready)
      else log_error("ready outputs low after init_done");
    end_test("reset state");

    for (k = 0; k < 3; k++) begin
      wa = 24'(rand_bits(24));
      wl = 1 + rand_bits(9) + rand_bits(7);
      run_jobs(1'b1, 1'b0, wa, wl, '0, 0, 1'b0);
    end
    end_test("stage splitting");

    wa = 24'(rand_bits(24)) | 24'h0001f0;  // column 496 or above
    wl = 600 + rand_bits(8);
    run_jobs(1'b1, 1'b0, wa, wl, '0, 0, 1'b0);
    end_test("write round trip");

    ra = wa;
    run_jobs(1'b0, 1'b1, '0, 0, ra, wl, 1'b0);
    end_test("read round trip");

    // write data buffered first so both channels go pending in one cycle
    wa = ra ^ 24'h800000;  // far from the read region
    wl = 1 + rand_bits(6);
    wr_q.delete();
    push_words(wl, 1'b0);
    k = burst_log.size();
    run_jobs(1'b1, 1'b1, wa, wl, ra, 1 + rand_bits(8), 1'b1);
    assert (burst_log.size() > k && burst_log[k])
      else log_error("write burst requested ahead of the read");
    end_test("job gating and read priority");

    k = underrun_cnt;
    rd_req <= 1'b1;
    @(posedge clk_sdram);
    rd_req <= 1'b0;
    repeat (2) @(posedge clk_sdram);
    assert (underrun_cnt == k + 1)
      else log_error($sformatf("rd_underrun pulsed %0d times", underrun_cnt - k));
    k = overrun_cnt;
    wr_q.delete();
    push_words(1025, 1'b1);
    repeat (2) @(posedge clk_sdram);
    assert (overrun_cnt == k + 1 && !wr_rdy)
      else log_error($sformatf("wr_overrun pulsed %0d times, wr_rdy %b with a full fifo",
                               overrun_cnt - k, wr_rdy));
    void'(wr_q.pop_back());  // the dropped word
    wa = 24'(rand_bits(24)) & 24'hfffe00;
    run_jobs(1'b1, 1'b0, wa, 1024, '0, 0, 1'b1);
    run_jobs(1'b0, 1'b1, '0, 0, wa + 24'd500, 40, 1'b0);
    assert (overrun_cnt == 1 && underrun_cnt == 1)
      else log_error("misuse flag pulsed outside the misuse test");
    end_test("misuse flags");

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: dv/sdram_mcb_assert.sv
`timescale 1ns/1ps
module sdram_mcb_assert (
  input logic                               clk_sdram,
  input logic                               rst_n,
  input logic                               burst_wr_req,
  input logic                               burst_rd_req,
  input logic                               burst_wr_ack,
  input logic                               burst_rd_ack,
  input logic [sdram_mcb_pkg::addr_w-1:0]   burst_addr,
  input logic [sdram_mcb_pkg::stage_w-1:0]  burst_len,
  input logic                               wr_done,
  input logic                               rd_done
);

  // request waits for the core
  wr_req_held: assert property (@(posedge clk_sdram) disable iff (!rst_n)
    burst_wr_req && !burst_wr_ack |=> burst_wr_req)
    else $error("burst_wr_req dropped before its first ack");

  rd_req_held: assert property (@(posedge clk_sdram) disable iff (!rst_n)
    burst_rd_req && !burst_rd_ack |=> burst_rd_req)
    else $error("burst_rd_req dropped before its first ack");

  burst_stable: assert property (@(posedge clk_sdram) disable iff (!rst_n)
    burst_wr_req || burst_rd_req |=> $stable(burst_addr) && $stable(burst_len))
    else $error("burst_addr or burst_len moved while a request was high");

  one_req: assert property (@(posedge clk_sdram) disable iff (!rst_n)
    !(burst_wr_req && burst_rd_req))
    else $error("write and read requests high together");

  // done is a single-cycle pulse
  wr_done_pulse: assert property (@(posedge clk_sdram) disable iff (!rst_n)
    wr_done |=> !wr_done)
    else $error("wr_done longer than one cycle");

  rd_done_pulse: assert property (@(posedge clk_sdram) disable iff (!rst_n)
    rd_done |=> !rd_done)
    else $error("rd_done longer than one cycle");

endmodule

bind sdram_mcb sdram_mcb_assert u_assert (
  .clk_sdram    (clk_sdram),
  .rst_n        (rst_n),
  .burst_wr_req (burst_wr_req),
  .burst_rd_req (burst_rd_req),
  .burst_wr_ack (burst_wr_ack),
  .burst_rd_ack (burst_rd_ack),
  .burst_addr   (burst_addr),
  .burst_len    (burst_len),
  .wr_done      (wr_done),
  .rd_done      (rd_done)
);

// File: rtl/sdram_mcb.sv
`timescale 1ns/1ps
module sdram_mcb (
  input  logic                               clk_sdram,
  input  logic                               rst_n,
  input  logic                               core_init_done,  // command core ready
  // write job and data
  input  logic                               wr_load,
  output logic                               wr_load_ready,
  input  logic [sdram_mcb_pkg::addr_w-1:0]   wr_addr,         // {bank, row, col}
  input  logic [sdram_mcb_pkg::len_w-1:0]    wr_length,
  input  logic                               wr_req,
  input  logic [sdram_mcb_pkg::data_w-1:0]   din,
  output logic                               wr_done,
  output logic                               wr_rdy,
  output logic                               wr_overrun,
  // read job and data
  input  logic                               rd_load,
  output logic                               rd_load_ready,
  input  logic [sdram_mcb_pkg::addr_w-1:0]   rd_addr,
  input  logic [sdram_mcb_pkg::len_w-1:0]    rd_length,
  input  logic                               rd_req,
  output logic [sdram_mcb_pkg::data_w-1:0]   dout,
  output logic                               rd_done,
  output logic [sdram_mcb_pkg::cnt_w-1:0]    rd_fifo_cnt,
  output logic                               rd_fifo_empty,
  output logic                               rd_underrun,
  // burst port to the command core
  output logic                               burst_wr_req,
  output logic                               burst_rd_req,
  output logic [sdram_mcb_pkg::addr_w-1:0]   burst_addr,
  output logic [sdram_mcb_pkg::stage_w-1:0]  burst_len,
  input  logic                               burst_wr_ack,
  input  logic                               burst_rd_ack,
  output logic [sdram_mcb_pkg::data_w-1:0]   burst_wdata,
  input  logic [sdram_mcb_pkg::data_w-1:0]   burst_rdata
);

  sdram_mcb_pkg::mcb_addr_u          burst_addr_u;
  logic [sdram_mcb_pkg::cnt_w-1:0]   wr_fifo_cnt;
  logic                              wr_fifo_af;

  mcb_stage_if wr_stage ();
  mcb_stage_if rd_stage ();

  assign burst_addr = burst_addr_u.flat;
  assign wr_rdy     = core_init_done && !wr_fifo_af;

  // user pushes, core pops on each write ack
  mcb_fifo u_wr_fifo (
    .clk_sdram   (clk_sdram),
    .rst_n       (rst_n),
    .push        (wr_req),
    .pop         (wr_stage.beat),
    .wdata       (din),
    .rdata       (burst_wdata),
    .count       (wr_fifo_cnt),
    .empty       (),
    .almost_full (wr_fifo_af),
    .overrun     (wr_overrun),
    .underrun    ()
  );

  // core pushes on each read ack, user pops
  mcb_fifo u_rd_fifo (
    .clk_sdram   (clk_sdram),
    .rst_n       (rst_n),
    .push        (rd_stage.beat),
    .pop         (rd_req),
    .wdata       (burst_rdata),
    .rdata       (dout),
    .count       (rd_fifo_cnt),
    .empty       (rd_fifo_empty),
    .almost_full (),
    .overrun     (),
    .underrun    (rd_underrun)
  );

  mcb_job_channel #(.is_read(1'b0)) u_wr_chan (
    .clk_sdram  (clk_sdram),
    .rst_n      (rst_n),
    .load_valid (wr_load),
    .load_ready (wr_load_ready),
    .load_addr  (wr_addr),
    .load_len   (wr_length),
    .init_done  (core_init_done),
    .fifo_count (wr_fifo_cnt),
    .done       (wr_done),
    .stage      (wr_stage.channel)
  );

  mcb_job_channel #(.is_read(1'b1)) u_rd_chan (
    .clk_sdram  (clk_sdram),
    .rst_n      (rst_n),
    .load_valid (rd_load),
    .load_ready (rd_load_ready),
    .load_addr  (rd_addr),
    .load_len   (rd_length),
    .init_done  (core_init_done),
    .fifo_count (rd_fifo_cnt),
    .done       (rd_done),
    .stage      (rd_stage.channel)
  );

  mcb_scheduler u_sched (
    .clk_sdram    (clk_sdram),
    .rst_n        (rst_n),
    .wr_stage     (wr_stage.sched),
    .rd_stage     (rd_stage.sched),
    .burst_wr_req (burst_wr_req),
    .burst_rd_req (burst_rd_req),
    .burst_addr   (burst_addr_u),
    .burst_len    (burst_len),
    .burst_wr_ack (burst_wr_ack),
    .burst_rd_ack (burst_rd_ack)
  );

endmodule

// File: rtl/mcb_scheduler.sv
`timescale 1ns/1ps
module mcb_scheduler (
  input  logic                               clk_sdram,
  input  logic                               rst_n,
  mcb_stage_if.sched                         wr_stage,
  mcb_stage_if.sched                         rd_stage,
  output logic                               burst_wr_req,
  output logic                               burst_rd_req,
  output sdram_mcb_pkg::mcb_addr_u           burst_addr,
  output logic [sdram_mcb_pkg::stage_w-1:0]  burst_len,
  input  logic                               burst_wr_ack,
  input  logic                               burst_rd_ack
);

  logic [1:0]                        state;
  logic                              sel_rd;    // stage in flight is a read
  logic [sdram_mcb_pkg::stage_w-1:0] beat_cnt;  // acks seen this stage
  logic                              idle;
  logic                              pick_rd;
  logic                              pick_wr;
  logic                              in_burst;
  logic                              ack;
  logic                              last_beat;

  assign idle     = (state == sdram_mcb_pkg::sch_idle);
  assign pick_rd  = idle && rd_stage.can_start;                        // reads win
  assign pick_wr  = idle && !rd_stage.can_start && wr_stage.can_start;
  assign rd_stage.start = pick_rd;
  assign wr_stage.start = pick_wr;

  assign in_burst = (state == sdram_mcb_pkg::sch_req) ||
                    (state == sdram_mcb_pkg::sch_xfer);
  assign ack      = sel_rd ? burst_rd_ack : burst_wr_ack;  // only the active side counts
  assign last_beat = in_burst && ack && ((beat_cnt + 1'b1) == burst_len);

  // beats go straight to the fifos
  assign rd_stage.beat = in_burst && sel_rd && burst_rd_ack;
  assign wr_stage.beat = in_burst && !sel_rd && burst_wr_ack;

  assign rd_stage.stage_end = (state == sdram_mcb_pkg::sch_cplt) && sel_rd;
  assign wr_stage.stage_end = (state == sdram_mcb_pkg::sch_cplt) && !sel_rd;

  always_ff @(posedge clk_sdram or negedge rst_n) begin
    if (!rst_n) begin
      state        <= sdram_mcb_pkg::sch_idle;
      sel_rd       <= 1'b0;
      beat_cnt     <= '0;
      burst_wr_req <= 1'b0;
      burst_rd_req <= 1'b0;
    end else begin
      case (state)
        sdram_mcb_pkg::sch_idle: begin
          if (pick_rd || pick_wr) begin
            state        <= sdram_mcb_pkg::sch_req;
            sel_rd       <= pick_rd;
            beat_cnt     <= '0;
            burst_rd_req <= pick_rd;  // request rises a cycle after start
            burst_wr_req <= pick_wr;
          end
        end
        sdram_mcb_pkg::sch_req: begin
          if (ack) begin
            burst_rd_req <= 1'b0;  // drop on first ack
            burst_wr_req <= 1'b0;
            beat_cnt     <= beat_cnt + 1'b1;
            state        <= last_beat ? sdram_mcb_pkg::sch_cplt : sdram_mcb_pkg::sch_xfer;
          end
        end
        sdram_mcb_pkg::sch_xfer: begin
          if (ack) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) state <= sdram_mcb_pkg::sch_cplt;
          end
        end
        default: begin
          state <= sdram_mcb_pkg::sch_idle;  // stage_end issued here
        end
      endcase
    end
  end

  // latch the stage at start, held through the last ack
  always_ff @(posedge clk_sdram) begin
    if (pick_rd) begin
      burst_addr <= rd_stage.stage_addr;
      burst_len  <= rd_stage.stage_len;
    end else if (pick_wr) begin
      burst_addr <= wr_stage.stage_addr;
      burst_len  <= wr_stage.stage_len;
    end
  end

endmodule

// File: rtl/mcb_job_channel.sv
`timescale 1ns/1ps
module mcb_job_channel #(
  parameter bit is_read = 1'b0  // selects the fifo room rule
) (
  input  logic                             clk_sdram,
  input  logic                             rst_n,
  input  logic                             load_valid,
  output logic                             load_ready,
  input  sdram_mcb_pkg::mcb_addr_u         load_addr,
  input  logic [sdram_mcb_pkg::len_w-1:0]  load_len,
  input  logic                             init_done,
  input  logic [sdram_mcb_pkg::cnt_w-1:0]  fifo_count,
  output logic                             done,
  mcb_stage_if.channel                     stage
);

  sdram_mcb_pkg::mcb_addr_u               addr;       // next stage start
  logic [sdram_mcb_pkg::len_w-1:0]        remaining;  // words still to move
  logic [sdram_mcb_pkg::stage_w-1:0]      row_room;   // words to end of row
  logic [sdram_mcb_pkg::cnt_w:0]          rd_sum;     // read fifo after the stage
  logic                                   busy;       // stage handed out
  logic                                   take;
  logic                                   last_stage;
  logic                                   room_ok;

  assign load_ready = init_done && !stage.pending;
  assign take       = load_valid && load_ready;

  // stage never crosses the row end
  assign row_room = sdram_mcb_pkg::stage_w'(sdram_mcb_pkg::col_span) -
                    sdram_mcb_pkg::stage_w'(addr.f.col);
  assign stage.stage_len  = (remaining < sdram_mcb_pkg::len_w'(row_room)) ?
                            remaining[sdram_mcb_pkg::stage_w-1:0] : row_room;
  assign stage.stage_addr = addr;
  assign last_stage = (remaining == sdram_mcb_pkg::len_w'(stage.stage_len));

  assign rd_sum = fifo_count + stage.stage_len;
  // read needs space left, write needs the whole stage buffered
  assign room_ok = is_read ?
                   (rd_sum < (sdram_mcb_pkg::cnt_w + 1)'(sdram_mcb_pkg::rd_room_limit)) :
                   (fifo_count >= sdram_mcb_pkg::cnt_w'(stage.stage_len));
  assign stage.can_start = stage.pending && !busy && room_ok;

  always_ff @(posedge clk_sdram or negedge rst_n) begin
    if (!rst_n) begin
      stage.pending <= 1'b0;
      busy          <= 1'b0;
      done          <= 1'b0;
    end else begin
      done <= stage.stage_end && last_stage;  // one cycle after final stage_end
      if (take) begin
        stage.pending <= 1'b1;
      end else if (stage.stage_end && last_stage) begin
        stage.pending <= 1'b0;
      end
      if (stage.start) begin
        busy <= 1'b1;
      end else if (stage.stage_end) begin
        busy <= 1'b0;
      end
    end
  end

  // address and length only move at load or stage_end
  always_ff @(posedge clk_sdram) begin
    if (take) begin
      addr      <= load_addr;
      remaining <= load_len;
    end else if (stage.stage_end) begin
      addr.flat <= addr.flat + sdram_mcb_pkg::addr_w'(stage.stage_len);
      remaining <= remaining - sdram_mcb_pkg::len_w'(stage.stage_len);
    end
  end

endmodule

// File: rtl/mcb_fifo.sv
`timescale 1ns/1ps
module mcb_fifo (
  input  logic                              clk_sdram,
  input  logic                              rst_n,
  input  logic                              push,
  input  logic                              pop,
  input  logic [sdram_mcb_pkg::data_w-1:0]  wdata,
  output logic [sdram_mcb_pkg::data_w-1:0]  rdata,
  output logic [sdram_mcb_pkg::cnt_w-1:0]   count,
  output logic                              empty,
  output logic                              almost_full,
  output logic                              overrun,
  output logic                              underrun
);

  logic [sdram_mcb_pkg::data_w-1:0] mem [sdram_mcb_pkg::fifo_depth];
  logic [sdram_mcb_pkg::cnt_w-2:0]  wptr;  // wraps at depth
  logic [sdram_mcb_pkg::cnt_w-2:0]  rptr;
  logic                             full;
  logic                             do_push;
  logic                             do_pop;

  assign full        = (count == sdram_mcb_pkg::cnt_w'(sdram_mcb_pkg::fifo_depth));
  assign empty       = (count == '0);
  assign almost_full = (count >= sdram_mcb_pkg::cnt_w'(sdram_mcb_pkg::fifo_depth -
                                                       sdram_mcb_pkg::almost_full_margin));
  assign do_push     = push && !full;  // drop word when full
  assign do_pop      = pop && !empty;
  assign rdata       = mem[rptr];      // show-ahead head

  always_ff @(posedge clk_sdram) begin
    if (do_push) mem[wptr] <= wdata;
  end

  always_ff @(posedge clk_sdram or negedge rst_n) begin
    if (!rst_n) begin
      wptr     <= '0;
      rptr     <= '0;
      count    <= '0;
      overrun  <= 1'b0;
      underrun <= 1'b0;
    end else begin
      if (do_push) wptr <= wptr + 1'b1;
      if (do_pop) rptr <= rptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
      overrun  <= push && full;   // one-cycle misuse pulses
      underrun <= pop && empty;
    end
  end

endmodule

// File: rtl/mcb_stage_if.sv
`timescale 1ns/1ps
interface mcb_stage_if;

  logic                                   pending;    // job loaded, words left
  logic                                   can_start;  // fifo can serve the whole stage
  sdram_mcb_pkg::mcb_addr_u               stage_addr;
  logic [sdram_mcb_pkg::stage_w-1:0]      stage_len;
  logic                                   start;      // scheduler took the stage
  logic                                   beat;       // one word moved
  logic                                   stage_end;  // last beat was one cycle ago

  modport channel (
    output pending, can_start, stage_addr, stage_len,
    input  start, stage_end
  );

  modport sched (
    input  can_start, stage_addr, stage_len,
    output start, beat, stage_end
  );

endinterface

// File: rtl/sdram_mcb_pkg.sv
package sdram_mcb_pkg;

  localparam int data_w             = 16;   // sdram dq width
  localparam int addr_w             = 24;   // word address
  localparam int len_w              = 24;   // job length in words
  localparam int bank_w             = 2;
  localparam int row_w              = 13;
  localparam int col_w              = 9;
  localparam int col_span           = 512;  // words per row
  localparam int fifo_depth         = 1024;
  localparam int cnt_w              = 11;   // holds 0..1024
  localparam int rd_room_limit      = 1023; // read fifo must stay below this
  localparam int stage_w            = 10;   // one stage is at most col_span
  localparam int almost_full_margin = 4;

  // scheduler state codes
  localparam logic [1:0] sch_idle = 2'd0;
  localparam logic [1:0] sch_req  = 2'd1; // request held until first ack
  localparam logic [1:0] sch_xfer = 2'd2; // remaining beats
  localparam logic [1:0] sch_cplt = 2'd3; // stage_end cycle

  // one address word, seen flat for stepping or split for the row end
  typedef union packed {
    logic [addr_w-1:0] flat;
    struct packed {
      logic [bank_w-1:0] bank;
      logic [row_w-1:0]  row;
      logic [col_w-1:0]  col;
    } f;
  } mcb_addr_u;

endpackage
